// File: hw/pc_guard_defines.svh
// PC hardening checker width definitions
// Shared by the package and by the comparator for address assembly

`ifndef PC_GUARD_DEFINES_SVH
`define PC_GUARD_DEFINES_SVH

// Width of a fetch PC or any target address
`define PC_GUARD_PC_W 32

// Width of the mtvec base field
// Exception target is this field followed by zero bits up to PC width
`define PC_GUARD_TVEC_W 25

`endif

// File: hw/pc_guard_pkg.sv
// PC hardening checker types
// Address vectors, the PC source selector and the bundles passed
// between capture, tracker and comparator

`include "pc_guard_defines.svh"

package pc_guard_pkg;

  // One PC or target address
  typedef logic [`PC_GUARD_PC_W-1:0]   pc_t;

  // Trap vector base as held in mtvec
  typedef logic [`PC_GUARD_TVEC_W-1:0] tvec_t;

  // Source of the next fetch PC as chosen by the controller
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_WB_PLUS4 = 3'd5
  } pc_mux_e;

  // Instruction currently held in ID
  typedef struct packed {
    logic instr_valid;
    pc_t  pc;
    logic compressed;
  } if_id_pipe_t;

  // Controller strobes for one cycle
  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
    logic    jump_in_id;
    logic    kill_id;
    logic    id_done;
  } ctrl_req_t;

  // Registered context handed from tracker to comparator
  typedef struct packed {
    logic    pc_set_q;
    logic    if_id_q;
    pc_mux_e pc_mux_q;
    logic    compare_enable_q;
    logic    jmp_taken_q;
    logic    enable_q;
  } check_ctx_t;

endpackage

// File: hw/if_id_capture.sv
// IF/ID capture for the PC hardening checker
// Holds the instruction that left IF and pulses when a transfer occurred,
// marking the following cycle as due for a sequential PC check

module if_id_capture (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      if_valid_i,
  input  logic                      id_ready_i,
  input  pc_guard_pkg::pc_t         pc_if_i,
  input  logic                      if_compressed_i,
  input  logic                      kill_id_i,
  output pc_guard_pkg::if_id_pipe_t if_id_pipe_o,
  output logic                      if_id_xfer_o
);

  ///////////////////////////////
  // Transfer detection
  ///////////////////////////////

  // IF hands over only when ID can accept
  logic xfer;
  logic instr_valid_q;
  logic xfer_q;

  // Payload of the ID stage copy
  pc_guard_pkg::pc_t pc_q;
  logic              compressed_q;

  assign xfer = if_valid_i && id_ready_i;

  // Valid bit and transfer pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_q <= 1'b0;
      xfer_q        <= 1'b0;
    end else begin
      xfer_q <= xfer;
      // A kill empties ID even if IF offers a new instruction
      if (kill_id_i) begin
        instr_valid_q <= 1'b0;
      end else if (xfer) begin
        instr_valid_q <= 1'b1;
      end
    end
  end

  // PC and size follow every transfer, held under back-pressure
  always_ff @(posedge clk) begin
    if (xfer) begin
      pc_q         <= pc_if_i;
      compressed_q <= if_compressed_i;
    end
  end

  ///////////////////////////////
  // Outputs
  ///////////////////////////////

  assign if_id_pipe_o.instr_valid = instr_valid_q;
  assign if_id_pipe_o.pc          = pc_q;
  assign if_id_pipe_o.compressed  = compressed_q;
  assign if_id_xfer_o             = xfer_q;

endmodule

// File: hw/pc_set_tracker.sv
// PC set tracker for the PC hardening checker
// Registers the controller's PC redirects, the selected PC source,
// the sticky compare enable, the jump taken flag and the delayed enable

module pc_set_tracker (
  input  logic                     clk,
  input  logic                     rst_n,
  input  pc_guard_pkg::ctrl_req_t  ctrl_i,
  input  logic                     hardening_en_i,
  input  logic                     if_id_valid_i,
  output pc_guard_pkg::check_ctx_t ctx_o
);

  // Registered redirect, excluding sources that cannot be recomputed
  logic                  pc_set_q;
  // Source of the last redirect
  pc_guard_pkg::pc_mux_e pc_mux_q;
  // Set by the first redirect after reset, never cleared
  logic                  compare_enable_q;
  // Jump or mret taken and instruction not yet retired from ID
  logic                  jmp_taken_q;
  // Hardening enable one cycle late
  logic                  enable_q;

  // Redirects whose target is recomputed by the comparator
  logic checked_set;
  // Redirects that come from a jump or mret in ID
  logic jump_set;

  assign checked_set = ctrl_i.pc_set && (ctrl_i.pc_mux != pc_guard_pkg::PC_WB_PLUS4);
  assign jump_set    = ctrl_i.pc_set &&
                       ((ctrl_i.pc_mux == pc_guard_pkg::PC_JUMP) ||
                        (ctrl_i.pc_mux == pc_guard_pkg::PC_MRET));

  ///////////////////////////////
  // Context registers
  ///////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_set_q         <= 1'b0;
      pc_mux_q         <= pc_guard_pkg::PC_BOOT;
      compare_enable_q <= 1'b0;
      jmp_taken_q      <= 1'b0;
      enable_q         <= 1'b0;
    end else begin
      pc_set_q <= checked_set;
      enable_q <= hardening_en_i;

      // Every redirect updates the source and arms checking
      if (ctrl_i.pc_set) begin
        pc_mux_q         <= ctrl_i.pc_mux;
        compare_enable_q <= 1'b1;
      end

      // Retire or kill of the jump in ID wins over a new jump
      if (ctrl_i.id_done || ctrl_i.kill_id) begin
        jmp_taken_q <= 1'b0;
      end else if (jump_set) begin
        jmp_taken_q <= 1'b1;
      end
    end
  end

  ///////////////////////////////
  // Context bundle
  ///////////////////////////////

  assign ctx_o.pc_set_q         = pc_set_q;
  // Sequential check applies only when no redirect was registered
  assign ctx_o.if_id_q          = if_id_valid_i && !pc_set_q;
  assign ctx_o.pc_mux_q         = pc_mux_q;
  assign ctx_o.compare_enable_q = compare_enable_q;
  assign ctx_o.jmp_taken_q      = jmp_taken_q;
  assign ctx_o.enable_q         = enable_q;

endmodule

// File: hw/pc_compare.sv
// PC comparator for the PC hardening checker
// Recomputes the expected fetch PC from the registered context,
// compares it with the IF stage PC and checks jump decisions in ID

`include "pc_guard_defines.svh"

module pc_compare (
  input  pc_guard_pkg::check_ctx_t  ctx_i,
  input  pc_guard_pkg::if_id_pipe_t if_id_pipe_i,
  input  logic                      if_id_xfer_i,
  input  pc_guard_pkg::pc_t         pc_if_i,
  input  logic                      jump_in_id_i,
  input  logic                      id_done_i,
  input  pc_guard_pkg::pc_t         jump_target_i,
  input  pc_guard_pkg::pc_t         branch_target_i,
  input  pc_guard_pkg::pc_t         mepc_i,
  input  pc_guard_pkg::tvec_t       mtvec_addr_i,
  input  pc_guard_pkg::pc_t         boot_addr_i,
  input  logic                      hardening_en_i,
  output logic                      pc_err_o
);

  // Zero padding below the mtvec base
  localparam int unsigned TVEC_PAD_W = `PC_GUARD_PC_W - `PC_GUARD_TVEC_W;

  pc_guard_pkg::pc_t incr_addr;
  pc_guard_pkg::pc_t ctrl_flow_addr;
  pc_guard_pkg::pc_t check_addr;

  logic addr_due;
  logic addr_err;
  logic dec_en;
  logic taken_err;
  logic untaken_err;

  ///////////////////////////////
  // Address recompute
  ///////////////////////////////

  // Next sequential PC after the instruction in ID
  assign incr_addr = if_id_pipe_i.pc +
                     (if_id_pipe_i.compressed ? pc_guard_pkg::pc_t'(2) : pc_guard_pkg::pc_t'(4));

  // Target chosen by the registered selector
  // A glitched selector picks a wrong source and shows up as a mismatch
  always_comb begin
    case (ctx_i.pc_mux_q)
      pc_guard_pkg::PC_JUMP:     ctrl_flow_addr = jump_target_i;
      pc_guard_pkg::PC_BRANCH:   ctrl_flow_addr = branch_target_i;
      pc_guard_pkg::PC_MRET:     ctrl_flow_addr = mepc_i;
      pc_guard_pkg::PC_TRAP_EXC: ctrl_flow_addr = {mtvec_addr_i, {TVEC_PAD_W{1'b0}}};
      default:                   ctrl_flow_addr = {boot_addr_i[`PC_GUARD_PC_W-1:2], 2'b00};
    endcase
  end

  // Redirect has priority, folded into the tracker's sequential flag
  // Bit 0 cleared since instructions are halfword aligned
  assign check_addr = ctx_i.if_id_q ? incr_addr :
                      {ctrl_flow_addr[`PC_GUARD_PC_W-1:1], 1'b0};

  // Check due the cycle after a redirect or an IF to ID transfer
  assign addr_due = ctx_i.pc_set_q || if_id_xfer_i;
  assign addr_err = hardening_en_i && addr_due && (check_addr != pc_if_i);

  ///////////////////////////////
  // Decision check
  ///////////////////////////////

  // First enabled cycle ignored, pipeline may hold stale state then
  assign dec_en = hardening_en_i && ctx_i.enable_q;

  // Taken jump must still have its jump in ID
  assign taken_err   = dec_en && ctx_i.jmp_taken_q && !jump_in_id_i;
  // Jump in ID finishing without having redirected
  assign untaken_err = dec_en && !ctx_i.jmp_taken_q && jump_in_id_i &&
                       if_id_pipe_i.instr_valid && id_done_i;

  // Nothing reported before the first redirect after reset
  assign pc_err_o = (addr_err || taken_err || untaken_err) && ctx_i.compare_enable_q;

endmodule

// File: hw/pc_guard_top.sv
// PC hardening checker top level
// Captures IF to ID transfers, tracks controller redirects and flags
// any fetch PC or jump decision that disagrees with the recomputed value

module pc_guard_top (
  input  logic                    clk,
  input  logic                    rst_n,
  // Fetch stage
  input  logic                    if_valid_i,
  input  logic                    id_ready_i,
  input  pc_guard_pkg::pc_t       pc_if_i,
  input  logic                    if_compressed_i,
  // Controller strobes
  input  pc_guard_pkg::ctrl_req_t ctrl_i,
  // Target sources
  input  pc_guard_pkg::pc_t       jump_target_i,
  input  pc_guard_pkg::pc_t       branch_target_i,
  input  pc_guard_pkg::pc_t       mepc_i,
  input  pc_guard_pkg::tvec_t     mtvec_addr_i,
  input  pc_guard_pkg::pc_t       boot_addr_i,
  input  logic                    hardening_en_i,
  output logic                    pc_err_o
);

  pc_guard_pkg::if_id_pipe_t if_id_pipe;
  logic                      if_id_xfer;
  pc_guard_pkg::check_ctx_t  ctx;

  if_id_capture u_capture (
    .clk             (clk),
    .rst_n           (rst_n),
    .if_valid_i      (if_valid_i),
    .id_ready_i      (id_ready_i),
    .pc_if_i         (pc_if_i),
    .if_compressed_i (if_compressed_i),
    .kill_id_i       (ctrl_i.kill_id),
    .if_id_pipe_o    (if_id_pipe),
    .if_id_xfer_o    (if_id_xfer)
  );

  pc_set_tracker u_tracker (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl_i         (ctrl_i),
    .hardening_en_i (hardening_en_i),
    .if_id_valid_i  (if_id_xfer),
    .ctx_o          (ctx)
  );

  pc_compare u_compare (
    .ctx_i           (ctx),
    .if_id_pipe_i    (if_id_pipe),
    .if_id_xfer_i    (if_id_xfer),
    .pc_if_i         (pc_if_i),
    .jump_in_id_i    (ctrl_i.jump_in_id),
    .id_done_i       (ctrl_i.id_done),
    .jump_target_i   (jump_target_i),
    .branch_target_i (branch_target_i),
    .mepc_i          (mepc_i),
    .mtvec_addr_i    (mtvec_addr_i),
    .boot_addr_i     (boot_addr_i),
    .hardening_en_i  (hardening_en_i),
    .pc_err_o        (pc_err_o)
  );

endmodule

// File: dv/pc_guard_assertions.sv
// Bound checks for the PC hardening checker
// A small reference model rebuilt from the checking rules gives the
// expected pc_err_o, one property per rule, each with a failure count

`include "pc_guard_defines.svh"

module pc_guard_assertions (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    if_valid_i,
  input logic                    id_ready_i,
  input pc_guard_pkg::pc_t       pc_if_i,
  input logic                    if_compressed_i,
  input pc_guard_pkg::ctrl_req_t ctrl_i,
  input pc_guard_pkg::pc_t       jump_target_i,
  input pc_guard_pkg::pc_t       branch_target_i,
  input pc_guard_pkg::pc_t       mepc_i,
  input pc_guard_pkg::tvec_t     mtvec_addr_i,
  input pc_guard_pkg::pc_t       boot_addr_i,
  input logic                    hardening_en_i,
  input logic                    pc_err_o
);

  localparam int unsigned TVEC_PAD_W = `PC_GUARD_PC_W - `PC_GUARD_TVEC_W;

  int fail_reset = 0;
  int fail_seq   = 0;
  int fail_flow  = 0;
  int fail_gate  = 0;
  int fail_dec   = 0;

  // Model state, all cleared by reset
  logic                  armed_q;
  logic                  xfer_q;
  logic                  set_q;
  logic                  taken_q;
  logic                  id_valid_q;
  logic                  en_q;
  pc_guard_pkg::pc_mux_e mux_q;
  // Next sequential PC, formed when the instruction leaves IF
  pc_guard_pkg::pc_t     seq_pc_q;
  pc_guard_pkg::pc_t     flow_target;

  logic seq_bad;
  logic flow_bad;
  logic dec_bad;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      armed_q    <= 1'b0;
      xfer_q     <= 1'b0;
      set_q      <= 1'b0;
      taken_q    <= 1'b0;
      id_valid_q <= 1'b0;
      en_q       <= 1'b0;
      mux_q      <= pc_guard_pkg::PC_BOOT;
      seq_pc_q   <= '0;
    end else begin
      armed_q <= armed_q || ctrl_i.pc_set;
      xfer_q  <= if_valid_i && id_ready_i;
      set_q   <= ctrl_i.pc_set && (ctrl_i.pc_mux != pc_guard_pkg::PC_WB_PLUS4);
      en_q    <= hardening_en_i;
      if (ctrl_i.pc_set) begin
        mux_q <= ctrl_i.pc_mux;
      end
      if (if_valid_i && id_ready_i) begin
        seq_pc_q <= pc_if_i + (if_compressed_i ? 32'd2 : 32'd4);
      end
      // Retire or kill beats a new taken jump
      if (ctrl_i.id_done || ctrl_i.kill_id) begin
        taken_q <= 1'b0;
      end else if (ctrl_i.pc_set && ((ctrl_i.pc_mux == pc_guard_pkg::PC_JUMP) ||
                                     (ctrl_i.pc_mux == pc_guard_pkg::PC_MRET))) begin
        taken_q <= 1'b1;
      end
      if (ctrl_i.kill_id) begin
        id_valid_q <= 1'b0;
      end else if (if_valid_i && id_ready_i) begin
        id_valid_q <= 1'b1;
      end
    end
  end

  // Redirect target from the latched source, read from current inputs
  always_comb begin
    case (mux_q)
      pc_guard_pkg::PC_JUMP:     flow_target = jump_target_i;
      pc_guard_pkg::PC_BRANCH:   flow_target = branch_target_i;
      pc_guard_pkg::PC_MRET:     flow_target = mepc_i;
      pc_guard_pkg::PC_TRAP_EXC: flow_target = {mtvec_addr_i, {TVEC_PAD_W{1'b0}}};
      default:                   flow_target = boot_addr_i & ~32'h3;
    endcase
    flow_target[0] = 1'b0;
  end

  assign seq_bad  = hardening_en_i && (pc_if_i != seq_pc_q);
  assign flow_bad = hardening_en_i && (pc_if_i != flow_target);
  assign dec_bad  = hardening_en_i && en_q &&
                    ((taken_q && !ctrl_i.jump_in_id) ||
                     (!taken_q && ctrl_i.jump_in_id && id_valid_q && ctrl_i.id_done));

  //////////////////////////////
  // Properties
  //////////////////////////////

  a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    !armed_q |-> !pc_err_o)
    else begin
      $error("pc_err_o raised before the first pc_set");
      fail_reset = fail_reset + 1;
    end

  a_sequential: assert property (@(posedge clk) disable iff (!rst_n)
    armed_q && xfer_q && !set_q |-> pc_err_o == (seq_bad || dec_bad))
    else begin
      $error("pc_err_o wrong on a sequential fetch");
      fail_seq = fail_seq + 1;
    end

  a_ctrl_flow: assert property (@(posedge clk) disable iff (!rst_n)
    armed_q && set_q |-> pc_err_o == (flow_bad || dec_bad))
    else begin
      $error("pc_err_o wrong after a redirect");
      fail_flow = fail_flow + 1;
    end

  a_enable_gate: assert property (@(posedge clk) disable iff (!rst_n)
    !hardening_en_i |-> !pc_err_o)
    else begin
      $error("pc_err_o raised while hardening is disabled");
      fail_gate = fail_gate + 1;
    end

  a_decision: assert property (@(posedge clk) disable iff (!rst_n)
    armed_q && !set_q && !xfer_q |-> pc_err_o == dec_bad)
    else begin
      $error("pc_err_o wrong on a jump decision");
      fail_dec = fail_dec + 1;
    end

endmodule

bind pc_guard_top pc_guard_assertions u_checks (
  .clk             (clk),
  .rst_n           (rst_n),
  .if_valid_i      (if_valid_i),
  .id_ready_i      (id_ready_i),
  .pc_if_i         (pc_if_i),
  .if_compressed_i (if_compressed_i),
  .ctrl_i          (ctrl_i),
  .jump_target_i   (jump_target_i),
  .branch_target_i (branch_target_i),
  .mepc_i          (mepc_i),
  .mtvec_addr_i    (mtvec_addr_i),
  .boot_addr_i     (boot_addr_i),
  .hardening_en_i  (hardening_en_i),
  .pc_err_o        (pc_err_o)
);

// File: dv/pc_guard_tb.sv
// Testbench for the PC hardening checker
// Drives fetch, controller and target inputs through five tests
// Bound assertions judge pc_err_o and keep failure counts

`include "pc_guard_defines.svh"

module pc_guard_tb;

  // Tests plus reset take about 105 cycles
  localparam int MAX_CYCLES = 400;

  logic                    clk;
  logic                    rst_n;
  logic                    if_valid;
  logic                    id_ready;
  pc_guard_pkg::pc_t       pc_if;
  logic                    if_compressed;
  pc_guard_pkg::ctrl_req_t ctrl;
  pc_guard_pkg::pc_t       jump_target;
  pc_guard_pkg::pc_t       branch_target;
  pc_guard_pkg::pc_t       mepc;
  pc_guard_pkg::tvec_t     mtvec_addr;
  pc_guard_pkg::pc_t       boot_addr;
  logic                    hardening_en;
  logic                    pc_err;

  logic [31:0] lfsr;
  int          cycles = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  int          base_fails;

  pc_guard_top dut0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .if_valid_i      (if_valid),
    .id_ready_i      (id_ready),
    .pc_if_i         (pc_if),
    .if_compressed_i (if_compressed),
    .ctrl_i          (ctrl),
    .jump_target_i   (jump_target),
    .branch_target_i (branch_target),
    .mepc_i          (mepc),
    .mtvec_addr_i    (mtvec_addr),
    .boot_addr_i     (boot_addr),
    .hardening_en_i  (hardening_en),
    .pc_err_o        (pc_err)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run timed out after %0d cycles", cycles);
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic next_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return b;
  endfunction

  function automatic logic [31:0] rand_word(input int n);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < n; i++) begin
      w = {w[30:0], next_bit()};
    end
    return w;
  endfunction

  // Nonzero corruption that survives the bit 0 clear
  function automatic logic [31:0] flip_mask();
    return (rand_word(31) << 1) | 32'h2;
  endfunction

  function automatic pc_guard_pkg::pc_t expected_target(input pc_guard_pkg::pc_mux_e mux);
    pc_guard_pkg::pc_t t;
    case (mux)
      pc_guard_pkg::PC_JUMP:     t = jump_target;
      pc_guard_pkg::PC_BRANCH:   t = branch_target;
      pc_guard_pkg::PC_MRET:     t = mepc;
      pc_guard_pkg::PC_TRAP_EXC: t = {mtvec_addr, {(`PC_GUARD_PC_W-`PC_GUARD_TVEC_W){1'b0}}};
      default:                   t = boot_addr & ~32'h3;
    endcase
    t[0] = 1'b0;
    return t;
  endfunction

  function automatic int total_failures();
    return dut0.u_checks.fail_reset + dut0.u_checks.fail_seq + dut0.u_checks.fail_flow +
           dut0.u_checks.fail_gate + dut0.u_checks.fail_dec;
  endfunction

  // Next falling edge with strobes dropped and fresh targets
  task automatic tick();
    logic [31:0] w;
    @(negedge clk);
    ctrl.pc_set     = 1'b0;
    ctrl.jump_in_id = 1'b0;
    ctrl.kill_id    = 1'b0;
    ctrl.id_done    = 1'b0;
    if_valid        = 1'b0;
    id_ready        = 1'b1;
    jump_target     = rand_word(32);
    branch_target   = rand_word(32);
    mepc            = rand_word(32);
    boot_addr       = rand_word(32);
    w               = rand_word(`PC_GUARD_TVEC_W);
    mtvec_addr      = w[`PC_GUARD_TVEC_W-1:0];
  endtask

  task automatic pulse_set(input pc_guard_pkg::pc_mux_e mux);
    tick();
    ctrl.pc_set = 1'b1;
    ctrl.pc_mux = mux;
  endtask

  // Redirect then fetch the target
  // A jump retires right away
  task automatic redirect(input pc_guard_pkg::pc_mux_e mux, input logic corrupt);
    logic is_jump;
    is_jump = (mux == pc_guard_pkg::PC_JUMP) || (mux == pc_guard_pkg::PC_MRET);
    pulse_set(mux);
    tick();
    pc_if = expected_target(mux);
    if (corrupt) begin
      pc_if = pc_if ^ flip_mask();
    end
    ctrl.jump_in_id = is_jump;
    ctrl.id_done    = is_jump;
  endtask

  // Straight-line fetch with an optional bad PC and ID stall
  task automatic fetch_run(input int n, input int bad_at, input int stall_at);
    pc_guard_pkg::pc_t pc;
    pc = rand_word(32) & ~32'h1;
    for (int i = 0; i < n; i++) begin
      tick();
      if_valid      = 1'b1;
      if_compressed = next_bit();
      pc_if         = (i == bad_at) ? (pc ^ flip_mask()) : pc;
      if (i == stall_at) begin
        id_ready = 1'b0;
      end else begin
        pc = pc_if + (if_compressed ? 32'd2 : 32'd4);
      end
    end
  endtask

  task automatic end_test(input string name);
    // Lets the last driven cycle be checked
    tick();
    if (total_failures() == base_fails) begin
      $display("%s passed", name);
      n_pass = n_pass + 1;
    end else begin
      $display("error at %0t: %s, assertions failed", $time, name);
      n_fail = n_fail + 1;
    end
    base_fails = total_failures();
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    if_valid      = 1'b0;
    id_ready      = 1'b1;
    pc_if         = '0;
    if_compressed = 1'b0;
    ctrl          = '0;
    jump_target   = '0;
    branch_target = '0;
    mepc          = '0;
    mtvec_addr    = '0;
    boot_addr     = '0;
    hardening_en  = 1'b1;
    lfsr          = 32'h8b26_4f11;
    base_fails    = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Garbage fetches and jump retires before any redirect
    for (int i = 0; i < 6; i++) begin
      tick();
      if_valid        = 1'b1;
      pc_if           = rand_word(32);
      ctrl.jump_in_id = next_bit();
      ctrl.id_done    = ctrl.jump_in_id;
    end
    redirect(pc_guard_pkg::PC_BOOT, 1'b0);
    end_test("after_reset");

    fetch_run(12, 5, 8);
    fetch_run(8, -1, 3);
    end_test("sequential");

    redirect(pc_guard_pkg::PC_BOOT, 1'b0);
    redirect(pc_guard_pkg::PC_BOOT, 1'b1);
    redirect(pc_guard_pkg::PC_JUMP, 1'b0);
    redirect(pc_guard_pkg::PC_JUMP, 1'b1);
    redirect(pc_guard_pkg::PC_BRANCH, 1'b0);
    redirect(pc_guard_pkg::PC_BRANCH, 1'b1);
    redirect(pc_guard_pkg::PC_MRET, 1'b0);
    redirect(pc_guard_pkg::PC_MRET, 1'b1);
    redirect(pc_guard_pkg::PC_TRAP_EXC, 1'b0);
    redirect(pc_guard_pkg::PC_TRAP_EXC, 1'b1);
    // Refetch after WB is exempt
    redirect(pc_guard_pkg::PC_WB_PLUS4, 1'b1);
    end_test("control_flow");

    tick();
    hardening_en = 1'b0;
    redirect(pc_guard_pkg::PC_BRANCH, 1'b1);
    fetch_run(6, 3, -1);
    // Taken jump left without a jump in ID
    pulse_set(pc_guard_pkg::PC_JUMP);
    tick();
    pc_if = expected_target(pc_guard_pkg::PC_JUMP);
    tick();
    // Pending taken error held back in the first enabled cycle
    pulse_set(pc_guard_pkg::PC_BRANCH);
    tick();
    hardening_en = 1'b1;
    pc_if        = expected_target(pc_guard_pkg::PC_BRANCH);
    // Taken error shows once the delayed enable is up
    tick();
    ctrl.kill_id = 1'b1;
    tick();
    hardening_en = 1'b0;
    // Bad target lands in the first enabled cycle
    pulse_set(pc_guard_pkg::PC_BRANCH);
    tick();
    hardening_en = 1'b1;
    pc_if        = expected_target(pc_guard_pkg::PC_BRANCH) ^ flip_mask();
    end_test("enable_gating");

    pulse_set(pc_guard_pkg::PC_JUMP);
    tick();
    pc_if = expected_target(pc_guard_pkg::PC_JUMP);
    tick();
    ctrl.kill_id = 1'b1;
    tick();
    // Jump in ID retiring untaken
    if_valid      = 1'b1;
    if_compressed = 1'b0;
    pc_if         = rand_word(32) & ~32'h1;
    tick();
    pc_if           = pc_if + 32'd4;
    ctrl.jump_in_id = 1'b1;
    ctrl.id_done    = 1'b1;
    // Taken mret retired by id_done then taken jump killed
    pulse_set(pc_guard_pkg::PC_MRET);
    tick();
    pc_if           = expected_target(pc_guard_pkg::PC_MRET);
    ctrl.jump_in_id = 1'b1;
    tick();
    ctrl.jump_in_id = 1'b1;
    ctrl.id_done    = 1'b1;
    pulse_set(pc_guard_pkg::PC_JUMP);
    tick();
    pc_if           = expected_target(pc_guard_pkg::PC_JUMP);
    ctrl.jump_in_id = 1'b1;
    tick();
    ctrl.jump_in_id = 1'b1;
    ctrl.kill_id    = 1'b1;
    tick();
    end_test("jump_decision");

    $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
    if (n_fail == 0 && total_failures() == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+hw
hw/pc_guard_pkg.sv
hw/if_id_capture.sv
hw/pc_set_tracker.sv
hw/pc_compare.sv
hw/pc_guard_top.sv
dv/pc_guard_assertions.sv
dv/pc_guard_tb.sv

// File: Makefile
# Verilator build and run for the PC hardening checker

VERILATOR ?= verilator
TOP       ?= pc_guard_tb
SIM_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -j 0
# Keep running after assertion errors so the testbench can report them
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(SIM_DIR) -f $(FILELIST)
	@out="$$(./$(SIM_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(SIM_DIR)
